// ==== fw_mem_pkg.sv ====
// Shared bus definitions for the firmware memory subsystem
// Request and response structs, region and mode enums, widths

`default_nettype none

package fw_mem_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  // Host word address, one word per address
  localparam int BUS_ADDR_W = 12;
  localparam int BUS_DATA_W = 32;
  // One write strobe per byte lane
  localparam int BUS_WE_W   = BUS_DATA_W / 8;
  // Lowest region select bit, region offset lives below it
  localparam int REGION_LSB = 10;

  // --------------------------------------------------------------------------
  // Bus payloads
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic                  cs;
    logic [BUS_WE_W-1:0]   we;
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_DATA_W-1:0] write_data;
  } bus_req_t;

  typedef struct packed {
    logic [BUS_DATA_W-1:0] read_data;
    logic                  ready;
  } bus_rsp_t;

  // Targets, from addr[11:10]
  typedef enum logic [1:0] {
    REGION_FW_RAM = 2'd0,
    REGION_MODE   = 2'd1,
    REGION_NONE   = 2'd2
  } mem_region_t;

  // One-way switch, only reset returns to firmware
  typedef enum logic {
    MODE_FW  = 1'b0,
    MODE_APP = 1'b1
  } cpu_mode_t;

endpackage

`default_nettype wire

// ==== fw_ram.sv ====
// Firmware RAM, two banks of 32-bit words
// Byte write strobes, access gated by CPU mode, registered ready

`timescale 1ns/1ns
`default_nettype none

module fw_ram #(
  parameter int RAM_ADDR_W = 9
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  fw_mem_pkg::cpu_mode_t mode,
  input  fw_mem_pkg::bus_req_t  req,
  output fw_mem_pkg::bus_rsp_t  rsp
);

  import fw_mem_pkg::*;

  // --------------------------------------------------------------------------
  // Geometry
  // --------------------------------------------------------------------------
  localparam int BANK_ADDR_W = RAM_ADDR_W - 1;
  localparam int BANK_DEPTH  = 1 << BANK_ADDR_W;

  // --------------------------------------------------------------------------
  // Registers and wires
  // --------------------------------------------------------------------------
  logic                   ready_reg;
  logic [BUS_DATA_W-1:0]  read_data_reg;

  logic                   access;
  logic                   bank_sel;
  logic [BANK_ADDR_W-1:0] bank_idx;
  logic [BUS_WE_W-1:0]    lane_we;
  logic [BUS_DATA_W-1:0]  bank_rd [2];

  // Top RAM address bit picks the bank
  // Anything above RAM_ADDR_W aliases
  assign bank_sel = req.addr[RAM_ADDR_W-1];
  assign bank_idx = req.addr[BANK_ADDR_W-1:0];

  // Only firmware mode reaches the array
  assign access  = req.cs && (mode == MODE_FW);
  assign lane_we = req.we & {BUS_WE_W{access}};

  // --------------------------------------------------------------------------
  // Banks
  // --------------------------------------------------------------------------
  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [BUS_DATA_W-1:0] mem [BANK_DEPTH];

    // Byte lane writes into the selected bank only
    always_ff @(posedge clk) begin
      if (bank_sel == b[0]) begin
        for (int i = 0; i < BUS_WE_W; i++) begin
          if (lane_we[i]) begin
            mem[bank_idx][8*i +: 8] <= req.write_data[8*i +: 8];
          end
        end
      end
    end

    // Async array read, registered below
    assign bank_rd[b] = mem[bank_idx];

    // Application mode leaves the addressed word untouched
    a_no_app_write: assert property (@(posedge clk) disable iff (!reset_n)
      (mode == MODE_APP) && req.cs && (bank_sel == b[0])
      |=> (mem[$past(bank_idx)] === $past(bank_rd[b])))
      else $error("fw_ram: byte lane written in application mode");
  end

  // --------------------------------------------------------------------------
  // Response registers
  // --------------------------------------------------------------------------
  // Ready one cycle after cs, whatever the mode
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= req.cs;
    end
  end

  // Word from the selected bank on a granted read
  // Zero for writes, idle cycles and application mode
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      read_data_reg <= '0;
    end else if (access && !(|req.we)) begin
      read_data_reg <= bank_rd[bank_sel];
    end else begin
      read_data_reg <= '0;
    end
  end

  assign rsp.read_data = read_data_reg;
  assign rsp.ready     = ready_reg;

endmodule

`default_nettype wire

// ==== fw_mode_ctrl.sv ====
// Sticky firmware/application mode register
// Status readback in bit 0, one-cycle ready

`timescale 1ns/1ns
`default_nettype none

module fw_mode_ctrl (
  input  logic                  clk,
  input  logic                  reset_n,
  input  fw_mem_pkg::bus_req_t  req,
  output fw_mem_pkg::bus_rsp_t  rsp,
  output fw_mem_pkg::cpu_mode_t mode
);

  import fw_mem_pkg::*;

  cpu_mode_t             mode_reg;
  logic                  ready_reg;
  logic [BUS_DATA_W-1:0] read_data_reg;
  logic                  set_app;

  // Offset 0, lane 0 strobed, data bit 0 high
  assign set_app = req.cs && req.we[0] && req.write_data[0]
                   && (req.addr[REGION_LSB-1:0] == '0);

  // --------------------------------------------------------------------------
  // Mode and handshake
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mode_reg      <= MODE_FW;
      ready_reg     <= 1'b0;
      read_data_reg <= '0;
    end else begin
      ready_reg <= req.cs;
      // No path back to firmware except reset
      if (set_app) begin
        mode_reg <= MODE_APP;
      end
      // Status on reads, zero otherwise
      if (req.cs && !(|req.we)) begin
        read_data_reg <= {{(BUS_DATA_W-1){1'b0}}, mode_reg == MODE_APP};
      end else begin
        read_data_reg <= '0;
      end
    end
  end

  assign mode          = mode_reg;
  assign rsp.ready     = ready_reg;
  assign rsp.read_data = read_data_reg;

  // Once in application mode, stay there until reset
  a_mode_sticky: assert property (@(posedge clk) disable iff (!reset_n)
    (mode_reg == MODE_APP) |=> (mode_reg == MODE_APP))
    else $error("fw_mode_ctrl: left application mode without reset");

endmodule

`default_nettype wire

// ==== fw_bus_decoder.sv ====
// Host bus address decoder
// Region decode, target cs gating, response mux, unmapped responder

`timescale 1ns/1ns
`default_nettype none

module fw_bus_decoder #(
  parameter int RAM_ADDR_W = 9
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  fw_mem_pkg::bus_req_t host_req,
  output fw_mem_pkg::bus_rsp_t host_rsp,
  output fw_mem_pkg::bus_req_t ram_req,
  output fw_mem_pkg::bus_req_t mode_req,
  input  fw_mem_pkg::bus_rsp_t ram_rsp,
  input  fw_mem_pkg::bus_rsp_t mode_rsp
);

  import fw_mem_pkg::*;

  // --------------------------------------------------------------------------
  // Registers and wires
  // --------------------------------------------------------------------------
  mem_region_t region;
  mem_region_t region_reg;
  logic        none_ready_reg;

  // Region from addr[11:10]
  always_comb begin
    case (host_req.addr[BUS_ADDR_W-1:REGION_LSB])
      2'd0:    region = REGION_FW_RAM;
      2'd1:    region = REGION_MODE;
      default: region = REGION_NONE;
    endcase
  end

  // --------------------------------------------------------------------------
  // Request routing
  // --------------------------------------------------------------------------
  // Same payload to both targets, cs only to the selected one
  always_comb begin
    ram_req      = host_req;
    ram_req.cs   = host_req.cs && (region == REGION_FW_RAM);
    // RAM sees its own word index only
    ram_req.addr = BUS_ADDR_W'(host_req.addr[RAM_ADDR_W-1:0]);

    mode_req      = host_req;
    mode_req.cs   = host_req.cs && (region == REGION_MODE);
    // Region bits stripped, offset kept
    mode_req.addr = BUS_ADDR_W'(host_req.addr[REGION_LSB-1:0]);
  end

  // --------------------------------------------------------------------------
  // Response side
  // --------------------------------------------------------------------------
  // Host may move addr as soon as it sees ready,
  // so the response follows the region latched with cs
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      region_reg     <= REGION_NONE;
      none_ready_reg <= 1'b0;
    end else begin
      if (host_req.cs) begin
        region_reg <= region;
      end
      // Unmapped accesses still complete
      none_ready_reg <= host_req.cs && (region == REGION_NONE);
    end
  end

  always_comb begin
    case (region_reg)
      REGION_FW_RAM: host_rsp = ram_rsp;
      REGION_MODE:   host_rsp = mode_rsp;
      default: begin
        host_rsp.read_data = '0;
        host_rsp.ready     = none_ready_reg;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Handshake checks
  // --------------------------------------------------------------------------
  // Target ready must trace back to a host cs one cycle earlier
  a_ready_after_cs: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(host_rsp.ready) |-> $past(host_req.cs))
    else $error("fw_bus_decoder: ready rose without cs");

  // Never two targets selected
  a_one_target: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0({ram_req.cs, mode_req.cs}))
    else $error("fw_bus_decoder: more than one target selected");

endmodule

`default_nettype wire

// ==== fw_mem_top.sv ====
// Firmware memory subsystem top level
// Decoder, banked RAM and mode register on one host bus

`timescale 1ns/1ns
`default_nettype none

module fw_mem_top #(
  parameter int RAM_ADDR_W = 9
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  fw_mem_pkg::bus_req_t  host_req,
  output fw_mem_pkg::bus_rsp_t  host_rsp,
  output fw_mem_pkg::cpu_mode_t mode
);

  import fw_mem_pkg::*;

  // Decoder to target links
  bus_req_t ram_req;
  bus_req_t mode_req;
  bus_rsp_t ram_rsp;
  bus_rsp_t mode_rsp;

  fw_bus_decoder #(.RAM_ADDR_W(RAM_ADDR_W)) u_decoder (
    .clk      (clk),
    .reset_n  (reset_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .ram_req  (ram_req),
    .mode_req (mode_req),
    .ram_rsp  (ram_rsp),
    .mode_rsp (mode_rsp)
  );

  fw_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_ram (
    .clk     (clk),
    .reset_n (reset_n),
    .mode    (mode),
    .req     (ram_req),
    .rsp     (ram_rsp)
  );

  // Mode feeds the RAM gate and the top port
  fw_mode_ctrl u_mode_ctrl (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (mode_req),
    .rsp     (mode_rsp),
    .mode    (mode)
  );

endmodule

`default_nettype wire

// ==== tb_fw_mem_checker.sv ====
// Bus checker for the firmware memory testbench
// Ready timing, read data and mode against the reference model

`timescale 1ns/1ns
`default_nettype none

module tb_fw_mem_checker (
  input  logic                  clk,
  input  logic                  reset_n,
  input  fw_mem_pkg::bus_req_t  host_req,
  input  fw_mem_pkg::bus_rsp_t  host_rsp,
  input  fw_mem_pkg::cpu_mode_t mode,
  input  logic [31:0]           exp_data,
  input  fw_mem_pkg::cpu_mode_t exp_mode,
  output int                    errors,
  output int                    checks
);

  import fw_mem_pkg::*;

  // Request side as sampled at the previous edge
  logic        cs_q;
  logic        read_q;
  logic [11:0] addr_q;
  logic [31:0] exp_data_q;
  cpu_mode_t   exp_mode_q;

  // --------------------------------------------------------------------------
  // Compare at every rising edge, before the DUT registers move
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    if (!reset_n) begin
      errors = 0;
      checks = 0;
      cs_q       <= 1'b0;
      read_q     <= 1'b0;
      addr_q     <= '0;
      exp_data_q <= '0;
      exp_mode_q <= MODE_FW;
    end else begin
      // Ready trails cs by exactly one cycle, both edges
      checks++;
      if (host_rsp.ready !== cs_q) begin
        errors++;
        $display("FAIL host_rsp.ready: expected %h, got %h", cs_q, host_rsp.ready);
      end
      // Read data only matters on a completed read
      if (host_rsp.ready && read_q) begin
        checks++;
        if (host_rsp.read_data !== exp_data_q) begin
          errors++;
          $display("FAIL host_rsp.read_data at addr %h: expected %h, got %h",
                   addr_q, exp_data_q, host_rsp.read_data);
        end
      end
      // Mode lags the model by the sampling edge
      checks++;
      if (mode !== exp_mode_q) begin
        errors++;
        $display("FAIL mode: expected %h, got %h", exp_mode_q, mode);
      end
      cs_q       <= host_req.cs;
      read_q     <= host_req.cs && (host_req.we == 4'h0);
      addr_q     <= host_req.addr;
      exp_data_q <= exp_data;
      exp_mode_q <= exp_mode;
    end
  end

endmodule

`default_nettype wire

// ==== tb_fw_mem.sv ====
// Testbench top for the firmware memory subsystem
// Clock, reset, stimulus, reference model, watchdog and summary

`timescale 1ns/1ns
`default_nettype none

module tb_fw_mem;

  import fw_mem_pkg::*;

  localparam int RAM_ADDR_W = 9;
  localparam int N_WORDS    = 1 << RAM_ADDR_W;
  localparam int N_RAND     = 150;
  // Fill and readback, two random phases, directed tests
  localparam int N_TXN      = 2 * N_WORDS + 2 * N_RAND + 100;
  localparam int WATCHDOG   = N_TXN * 4 + 200;

  logic        clk;
  logic        reset_n;
  bus_req_t    host_req;
  bus_rsp_t    host_rsp;
  cpu_mode_t   mode;
  logic [31:0] exp_data;
  cpu_mode_t   model_mode;
  logic [31:0] model_mem [N_WORDS];
  int          errors;
  int          checks;
  int          bus_errors;
  int          test_errors;
  int          tests_done;
  int          seed;

  fw_mem_top #(.RAM_ADDR_W(RAM_ADDR_W)) UUT (
    .clk      (clk),
    .reset_n  (reset_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .mode     (mode)
  );

  tb_fw_mem_checker u_checker (
    .clk      (clk),
    .reset_n  (reset_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .mode     (mode),
    .exp_data (exp_data),
    .exp_mode (model_mode),
    .errors   (errors),
    .checks   (checks)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  // Expected read data, model state moves on writes
  function automatic logic [31:0] model_access(bus_req_t r);
    int          idx;
    logic [31:0] rd;
    // RAM aliases above its own address width
    idx = int'(r.addr[RAM_ADDR_W-1:0]);
    rd  = '0;
    case (r.addr[11:10])
      2'd0: begin
        if (model_mode == MODE_FW) begin
          for (int i = 0; i < 4; i++) begin
            if (r.we[i]) begin
              model_mem[idx][8*i +: 8] = r.write_data[8*i +: 8];
            end
          end
          if (r.we == 4'h0) begin
            rd = model_mem[idx];
          end
        end
      end
      2'd1: begin
        // Switch only at offset 0, lane 0, data bit 0
        if (r.we[0] && r.write_data[0] && (r.addr[9:0] == 10'd0)) begin
          model_mode = MODE_APP;
        end
        if (r.we == 4'h0) begin
          rd = {31'b0, model_mode == MODE_APP};
        end
      end
      default: rd = '0;
    endcase
    return rd;
  endfunction

  // --------------------------------------------------------------------------
  // Stimulus helpers, entered and left just after a falling edge
  // --------------------------------------------------------------------------
  task automatic bus_access(input logic [3:0] we, input logic [11:0] addr,
                            input logic [31:0] wdata, input int hold);
    int waited;
    waited   = 0;
    host_req = '{cs: 1'b1, we: we, addr: addr, write_data: wdata};
    exp_data = model_access(host_req);
    do begin
      @(negedge clk);
      waited++;
    end while (!host_rsp.ready && waited < 8);
    if (!host_rsp.ready) begin
      bus_errors++;
      $display("no ready within 8 cycles of cs at addr %h", addr);
    end
    // Extra cycles with cs still high, then one idle cycle
    repeat (hold) @(negedge clk);
    host_req.cs = 1'b0;
    @(negedge clk);
  endtask

  task automatic random_mix(input int n, input logic keep_fw);
    logic [31:0] rnd;
    logic [31:0] data;
    repeat (n) begin
      rnd  = $random(seed);
      data = $random(seed);
      // No mode switch before the directed test
      if (keep_fw && rnd[11:10] == 2'd1) begin
        data[0] = 1'b0;
      end
      bus_access(rnd[15] ? rnd[19:16] : 4'h0, rnd[11:0], data,
                 (rnd[31:30] == 2'b11) ? 1 : 0);
    end
  endtask

  task automatic finish_test(input string name);
    int now;
    now = errors + bus_errors;
    tests_done++;
    if (now == test_errors) begin
      $display("test %0d %s: ok", tests_done, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_done, name, now - test_errors);
    end
    test_errors = now;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] rnd;
    seed        = 89;
    reset_n     = 1'b0;
    host_req    = '0;
    exp_data    = '0;
    model_mode  = MODE_FW;
    bus_errors  = 0;
    test_errors = 0;
    tests_done  = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Whole RAM, both banks, pattern from the full address
    for (int a = 0; a < N_WORDS; a++) begin
      bus_access(4'hF, a[11:0], {4'hA, a[11:0], 4'h5, ~a[11:0]}, 0);
    end
    for (int a = 0; a < N_WORDS; a++) begin
      bus_access(4'h0, a[11:0], '0, 0);
    end
    finish_test("full words");

    repeat (24) begin
      rnd = $random(seed);
      bus_access(rnd[13:10], {2'b00, rnd[9:0]}, $random(seed), 0);
      bus_access(4'h0, {2'b00, rnd[9:0]}, '0, 0);
    end
    finish_test("byte strobes");

    for (int h = 1; h <= 3; h++) begin
      bus_access(4'hF, 12'h020, 32'hC0DE_0000 | h, h);
      bus_access(4'h0, 12'h020, '0, h);
      bus_access(4'h0, 12'h400, '0, h);
      bus_access(4'h0, 12'hC00, '0, h);
    end
    finish_test("held cs");

    for (int k = 0; k < 4; k++) begin
      rnd = $random(seed);
      bus_access(4'hF, {1'b1, rnd[10:0]}, rnd, 0);
      bus_access(4'h0, {1'b1, rnd[10:0]}, '0, 0);
      bus_access(4'h0, {2'b01, rnd[9:0]}, '0, 0);
    end
    finish_test("unmapped and mode reads");

    random_mix(N_RAND, 1'b1);
    finish_test("random, firmware mode");

    bus_access(4'h1, 12'h400, 32'h1, 0);
    bus_access(4'h0, 12'h400, '0, 0);
    bus_access(4'h0, 12'h020, '0, 0);
    bus_access(4'hF, 12'h0F0, 32'hDEAD_BEEF, 0);
    bus_access(4'h0, 12'h0F0, '0, 0);
    bus_access(4'h0, 12'h1F0, '0, 1);
    finish_test("mode switch");

    random_mix(N_RAND, 1'b0);
    finish_test("random, application mode");

    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors + bus_errors);
    if (errors + bus_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Bounded by the transaction count
  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
fw_mem_pkg.sv
fw_ram.sv
fw_mode_ctrl.sv
fw_bus_decoder.sv
fw_mem_top.sv
tb_fw_mem_checker.sv
tb_fw_mem.sv

// ==== Makefile ====
TOP := tb_fw_mem

all: run

run:
	verilator --binary --assert --top-module $(TOP) -f list.f -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
